//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // cache geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int offset_bits = 3;
  localparam int index_bits = 4;
  localparam int line_count = 2 ** index_bits;
  localparam int tag_bits = 32 - offset_bits - index_bits;
  localparam int line_bits = 64;

  // fetch starts here after reset
  localparam logic [31:0] reset_pc = 32'h3000_0000;

  // top address byte of the region that always goes to the bus
  localparam logic [7:0] uncached_region = 8'h0f;

  typedef enum logic [1:0] {
    refill_idle,
    refill_addr,
    refill_data
  } refill_state_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shared payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // data holds the lower word in bits 31:0 and the upper word in 63:32
  typedef struct packed {
    logic                 valid;
    logic [tag_bits-1:0]  tag;
    logic [line_bits-1:0] data;
  } cache_line_t;

  typedef struct packed {
    logic [31:0] pc;
    logic        cacheable;
  } miss_req_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } refill_resp_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_out_t;

endpackage

`default_nettype wire

//--- hdl/icache_array.sv
`timescale 1ns/1ns
`default_nettype none

module icache_array (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                flush,
  input  logic [fetch_pkg::index_bits-1:0]    read_index,
  output fetch_pkg::cache_line_t              read_line,
  input  logic                                line_write,
  input  logic [fetch_pkg::index_bits-1:0]    line_index,
  input  fetch_pkg::cache_line_t              write_line
);

  fetch_pkg::cache_line_t lines [fetch_pkg::line_count];

  // lookup sees the line for its pc in the same cycle
  assign read_line = lines[read_index];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // line storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a flush in the same cycle as a write leaves every line invalid
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      for (int i = 0; i < fetch_pkg::line_count; i++) begin
        lines[i].valid <= 1'b0;
      end
    end else if (line_write) begin
      lines[line_index] <= write_line;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_lookup (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                redirect,
  input  logic [31:0]                         redirect_pc,
  output logic [fetch_pkg::index_bits-1:0]    read_index,
  input  fetch_pkg::cache_line_t              read_line,
  output logic                                miss_valid,
  input  logic                                miss_ready,
  output fetch_pkg::miss_req_t                miss_req,
  input  logic                                resp_valid,
  input  fetch_pkg::refill_resp_t             resp,
  output logic                                out_valid,
  input  logic                                out_ready,
  output fetch_pkg::fetch_out_t               fetch_out
);

  logic [31:0] pc;
  logic        waiting;
  logic        cacheable;
  logic        hit;
  logic        can_issue;

  assign read_index = pc[fetch_pkg::offset_bits +: fetch_pkg::index_bits];

  assign cacheable = pc[31:24] != fetch_pkg::uncached_region;

  // the uncached region never hits, whatever the array holds
  assign hit = cacheable && read_line.valid &&
               read_line.tag == pc[31 -: fetch_pkg::tag_bits];

  // the output register is free this cycle
  assign can_issue = !out_valid || out_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pc, output register and miss hand-off
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= fetch_pkg::reset_pc;
      out_valid <= 1'b0;
      miss_valid <= 1'b0;
      waiting <= 1'b0;
    end else begin
      if (miss_valid && miss_ready) begin
        miss_valid <= 1'b0;
      end

      if (redirect) begin
        // refill drops its own result, so nothing is awaited any more
        pc <= redirect_pc;
        out_valid <= 1'b0;
        waiting <= 1'b0;
      end else if (waiting) begin
        if (resp_valid) begin
          fetch_out.pc <= resp.pc;
          fetch_out.inst <= resp.inst;
          out_valid <= 1'b1;
          pc <= pc + 32'd4;
          waiting <= 1'b0;
        end
      end else if (!miss_valid) begin
        if (out_valid && out_ready) begin
          out_valid <= 1'b0;
        end
        if (can_issue) begin
          if (hit) begin
            fetch_out.pc <= pc;
            fetch_out.inst <= pc[2] ? read_line.data[63:32] : read_line.data[31:0];
            out_valid <= 1'b1;
            pc <= pc + 32'd4;
          end else if (miss_ready) begin
            // refill is idle, so this request is taken on the next cycle
            miss_valid <= 1'b1;
            miss_req.pc <= pc;
            miss_req.cacheable <= cacheable;
            waiting <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/line_refill.sv
`timescale 1ns/1ns
`default_nettype none

module line_refill (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                redirect,
  input  logic                                miss_valid,
  output logic                                miss_ready,
  input  fetch_pkg::miss_req_t                miss_req,
  output logic [31:0]                         araddr,
  output logic                                arvalid,
  input  logic                                arready,
  input  logic [31:0]                         rdata,
  input  logic                                rvalid,
  input  logic                                rlast,
  output logic                                rready,
  output logic                                line_write,
  output logic [fetch_pkg::index_bits-1:0]    line_index,
  output fetch_pkg::cache_line_t              write_line,
  output logic                                resp_valid,
  output fetch_pkg::refill_resp_t             resp
);

  fetch_pkg::refill_state_t state;
  fetch_pkg::miss_req_t     req;
  logic [31:0]              word0;
  logic [31:0]              word1;
  logic                     discard;
  logic                     keep;

  assign miss_ready = state == fetch_pkg::refill_idle;

  // the burst always starts at the line base
  assign araddr = {req.pc[31:fetch_pkg::offset_bits], {fetch_pkg::offset_bits{1'b0}}};

  assign line_index = req.pc[fetch_pkg::offset_bits +: fetch_pkg::index_bits];
  assign write_line.valid = 1'b1;
  assign write_line.tag = req.pc[31 -: fetch_pkg::tag_bits];
  assign write_line.data = {word1, word0};

  assign resp.pc = req.pc;
  assign resp.inst = req.pc[2] ? word1 : word0;

  // a redirect in the last beat's cycle also drops the result
  assign keep = !discard && !redirect;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // burst control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= fetch_pkg::refill_idle;
      arvalid <= 1'b0;
      rready <= 1'b0;
      line_write <= 1'b0;
      resp_valid <= 1'b0;
      discard <= 1'b0;
    end else begin
      line_write <= 1'b0;
      resp_valid <= 1'b0;
      case (state)
        fetch_pkg::refill_idle: begin
          if (miss_valid) begin
            arvalid <= 1'b1;
            discard <= redirect;
            state <= fetch_pkg::refill_addr;
          end
        end
        fetch_pkg::refill_addr: begin
          if (redirect) begin
            discard <= 1'b1;
          end
          if (arready) begin
            arvalid <= 1'b0;
            rready <= 1'b1;
            state <= fetch_pkg::refill_data;
          end
        end
        fetch_pkg::refill_data: begin
          if (redirect) begin
            discard <= 1'b1;
          end
          if (rvalid && rlast) begin
            rready <= 1'b0;
            resp_valid <= keep;
            line_write <= keep && req.cacheable;
            state <= fetch_pkg::refill_idle;
          end
        end
        default: state <= fetch_pkg::refill_idle;
      endcase
    end
  end

  // request and beat payloads
  always_ff @(posedge clock) begin
    if (miss_valid && miss_ready) begin
      req <= miss_req;
    end
    if (state == fetch_pkg::refill_data && rvalid) begin
      if (rlast) begin
        word1 <= rdata;
      end else begin
        word0 <= rdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  redirect,
  input  logic [31:0]           redirect_pc,
  input  logic                  flush,
  output logic [31:0]           araddr,
  output logic                  arvalid,
  input  logic                  arready,
  input  logic [31:0]           rdata,
  input  logic                  rvalid,
  input  logic                  rlast,
  output logic                  rready,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fetch_pkg::fetch_out_t fetch_out
);

  logic [fetch_pkg::index_bits-1:0] read_index;
  fetch_pkg::cache_line_t           read_line;
  logic                             miss_valid;
  logic                             miss_ready;
  fetch_pkg::miss_req_t             miss_req;
  logic                             resp_valid;
  fetch_pkg::refill_resp_t          resp;
  logic                             line_write;
  logic [fetch_pkg::index_bits-1:0] line_index;
  fetch_pkg::cache_line_t           write_line;

  fetch_lookup lookup_inst (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .read_index  (read_index),
    .read_line   (read_line),
    .miss_valid  (miss_valid),
    .miss_ready  (miss_ready),
    .miss_req    (miss_req),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .fetch_out   (fetch_out)
  );

  line_refill refill_inst (
    .clock      (clock),
    .reset      (reset),
    .redirect   (redirect),
    .miss_valid (miss_valid),
    .miss_ready (miss_ready),
    .miss_req   (miss_req),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .rlast      (rlast),
    .rready     (rready),
    .line_write (line_write),
    .line_index (line_index),
    .write_line (write_line),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  icache_array array_inst (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .read_index (read_index),
    .read_line  (read_line),
    .line_write (line_write),
    .line_index (line_index),
    .write_line (write_line)
  );

endmodule

`default_nettype wire

//--- testbench/fetch_checker.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_checker (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  redirect,
  input  logic [31:0]           redirect_pc,
  input  logic                  flush,
  input  logic [31:0]           araddr,
  input  logic                  arvalid,
  input  logic                  arready,
  input  logic                  rvalid,
  input  logic                  rlast,
  input  logic                  rready,
  input  logic                  out_valid,
  input  logic                  out_ready,
  input  fetch_pkg::fetch_out_t fetch_out,
  input  logic                  test_done,
  input  logic [31:0]           test_id,
  input  logic [31:0]           expected_reads,
  output int                    error_count
);

  logic [fetch_pkg::tag_bits-1:0]   tag_table [fetch_pkg::line_count];
  logic [fetch_pkg::line_count-1:0] valid_table;
  logic [31:0]                      exp_pc;
  logic [31:0]                      pending_addr;
  logic                             pending;
  logic                             pending_discard;
  logic                             last_valid;
  logic                             last_ready;
  logic                             last_redirect;
  fetch_pkg::fetch_out_t            last_out;
  int                               read_count;
  int                               test_errors;

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, expected);
    error_count++;
    test_errors++;
  endtask

  function automatic logic line_resident(input logic [31:0] addr);
    logic [fetch_pkg::index_bits-1:0] index;
    index = addr[fetch_pkg::offset_bits +: fetch_pkg::index_bits];
    return addr[31:24] != fetch_pkg::uncached_region && valid_table[index] &&
           tag_table[index] == addr[31 -: fetch_pkg::tag_bits];
  endfunction

  initial begin
    error_count = 0;
    test_errors = 0;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decoder side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clock) begin
    if (reset) begin
      exp_pc = fetch_pkg::reset_pc;
      valid_table = '0;
      pending = 1'b0;
      last_valid = 1'b0;
      read_count = 0;
    end else begin
      // a stalled instruction must stay put until it is taken
      if (last_valid && !last_ready && !last_redirect) begin
        if (!out_valid) report_value("out_valid", 32'd0, 32'd1);
        if (fetch_out.pc != last_out.pc) begin
          report_value("fetch_out.pc", fetch_out.pc, last_out.pc);
        end
        if (fetch_out.inst != last_out.inst) begin
          report_value("fetch_out.inst", fetch_out.inst, last_out.inst);
        end
      end
      if (out_valid && out_ready && !redirect) begin
        if (fetch_out.pc != exp_pc) report_value("fetch_out.pc", fetch_out.pc, exp_pc);
        if (fetch_out.inst != (exp_pc ^ 32'h5a5a_0000)) begin
          report_value("fetch_out.inst", fetch_out.inst, exp_pc ^ 32'h5a5a_0000);
        end
        exp_pc = exp_pc + 32'd4;
      end
      if (redirect) exp_pc = redirect_pc;

      // bus reads and the residency model
      if (arvalid && arready) begin
        read_count++;
        if (araddr[2:0] != 3'd0) report_value("araddr", araddr, {araddr[31:3], 3'd0});
        if (line_resident(araddr)) begin
          $display("ERROR at %0t ns: bus read of line %h that is already cached",
                   $time, araddr);
          error_count++;
          test_errors++;
        end
        pending = 1'b1;
        pending_addr = araddr;
        pending_discard = redirect;
      end else if (pending && redirect) begin
        pending_discard = 1'b1;
      end
      if (pending && rvalid && rready && rlast) begin
        if (!pending_discard && !redirect && pending_addr[31:24] != fetch_pkg::uncached_region) begin
          tag_table[pending_addr[fetch_pkg::offset_bits +: fetch_pkg::index_bits]] =
            pending_addr[31 -: fetch_pkg::tag_bits];
          valid_table[pending_addr[fetch_pkg::offset_bits +: fetch_pkg::index_bits]] = 1'b1;
        end
        pending = 1'b0;
      end
      if (flush) valid_table = '0;

      if (test_done) begin
        if (read_count != expected_reads) begin
          report_value("bus read count", read_count, expected_reads);
        end
        if (test_errors == 0) begin
          $display("test %0d passed, %0d bus reads", test_id, read_count);
        end else begin
          $display("test %0d failed with %0d errors", test_id, test_errors);
        end
        read_count = 0;
        test_errors = 0;
      end

      last_valid = out_valid;
      last_ready = out_ready;
      last_redirect = redirect;
      last_out = fetch_out;
    end
  end

endmodule

`default_nettype wire

//--- testbench/fetch_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit_tb;

  logic                  clock;
  logic                  reset;
  logic                  redirect;
  logic [31:0]           redirect_pc;
  logic                  flush;
  logic [31:0]           araddr;
  logic                  arvalid;
  logic                  arready;
  logic [31:0]           rdata;
  logic                  rvalid;
  logic                  rlast;
  logic                  rready;
  logic                  out_valid;
  logic                  out_ready;
  fetch_pkg::fetch_out_t fetch_out;
  logic                  test_done;
  logic [31:0]           test_id;
  logic [31:0]           expected_reads;
  logic [31:0]           vectors [256];
  int                    error_count;
  int                    seed;
  int                    cycle_count;
  int                    cycle_limit;
  int                    bad_commands;

  fetch_unit fetch_unit_inst (
    .clock(clock), .reset(reset), .redirect(redirect), .redirect_pc(redirect_pc),
    .flush(flush), .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rvalid(rvalid), .rlast(rlast), .rready(rready),
    .out_valid(out_valid), .out_ready(out_ready), .fetch_out(fetch_out)
  );

  fetch_checker checker_inst (
    .clock(clock), .reset(reset), .redirect(redirect), .redirect_pc(redirect_pc),
    .flush(flush), .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rvalid(rvalid), .rlast(rlast), .rready(rready), .out_valid(out_valid),
    .out_ready(out_ready), .fetch_out(fetch_out), .test_done(test_done),
    .test_id(test_id), .expected_reads(expected_reads), .error_count(error_count)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the fetch unit stopped making progress", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus memory, word at a is a xor 5a5a0000
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    logic [31:0] addr;
    int          wait_cycles;
    forever begin
      @(negedge clock);
      if (arvalid) begin
        addr = araddr;
        wait_cycles = $random(seed) & 3;
        repeat (wait_cycles) @(negedge clock);
        arready = 1'b1;
        @(negedge clock);
        arready = 1'b0;
        for (int beat = 0; beat < 2; beat++) begin
          wait_cycles = $random(seed) & 3;
          repeat (wait_cycles) @(negedge clock);
          rvalid = 1'b1;
          rlast = beat == 1;
          rdata = (addr + 32'(beat * 4)) ^ 32'h5a5a_0000;
          @(negedge clock);
          rvalid = 1'b0;
          rlast = 1'b0;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decoder side stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic deliver(input int count, input logic random_ready);
    int delivered;
    int draw;
    delivered = 0;
    while (delivered < count) begin
      @(negedge clock);
      draw = $random(seed);
      out_ready = random_ready ? draw[0] : 1'b1;
      @(posedge clock);
      if (out_valid && out_ready) delivered++;
    end
    @(negedge clock);
    out_ready = 1'b0;
  endtask

  // the next instruction sits in the output register and no burst is running
  task automatic wait_idle();
    do begin
      @(posedge clock);
    end while (!(out_valid && !arvalid && !rready));
  endtask

  task automatic redirect_to(input logic [31:0] target, input logic with_flush);
    @(negedge clock);
    out_ready = 1'b0;
    redirect = 1'b1;
    redirect_pc = target;
    flush = with_flush;
    @(negedge clock);
    redirect = 1'b0;
    flush = 1'b0;
  endtask

  task automatic wait_address_transfer();
    do begin
      @(negedge clock);
      out_ready = 1'b1;
      @(posedge clock);
    end while (!(arvalid && arready));
  endtask

  initial begin
    int          total;
    int          index;
    logic [31:0] command;
    clock = 1'b0;
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    flush = 1'b0;
    arready = 1'b0;
    rdata = '0;
    rvalid = 1'b0;
    rlast = 1'b0;
    out_ready = 1'b0;
    test_done = 1'b0;
    test_id = '0;
    expected_reads = '0;
    seed = 32'hb7035330;
    cycle_count = 0;
    bad_commands = 0;
    for (int i = 0; i < 256; i++) vectors[i] = '0;
    $readmemh("testbench/fetch_vectors.txt", vectors);

    total = 0;
    for (int i = 0; i < 250 && vectors[i] != 0; i += 5) begin
      total += int'(vectors[i + 4]);
    end
    cycle_limit = 4 * total + 200;

    repeat (5) @(negedge clock);
    reset = 1'b0;

    index = 0;
    while (index < 250 && vectors[index] != 0) begin
      command = vectors[index];
      case (command)
        32'd1: deliver(int'(vectors[index + 1]), 1'b0);
        32'd2: deliver(int'(vectors[index + 1]), 1'b1);
        32'd3: begin
          redirect_to(vectors[index + 2], 1'b0);
          deliver(int'(vectors[index + 1]), 1'b0);
        end
        32'd4: begin
          wait_address_transfer();
          redirect_to(vectors[index + 2], 1'b0);
          deliver(int'(vectors[index + 1]), 1'b0);
        end
        32'd5: begin
          redirect_to(vectors[index + 2], 1'b1);
          deliver(int'(vectors[index + 1]), 1'b0);
        end
        default: begin
          $display("unknown command %0d in the vector file", command);
          bad_commands++;
        end
      endcase
      wait_idle();
      @(negedge clock);
      test_done = 1'b1;
      test_id = 32'(index / 5 + 1);
      expected_reads = vectors[index + 3];
      @(negedge clock);
      test_done = 1'b0;
      index += 5;
    end

    repeat (2) @(negedge clock);
    $display("%0d tests run, %0d errors, %0d bad commands", index / 5, error_count, bad_commands);
    if (error_count == 0 && bad_commands == 0 && index > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_unit.f
hdl/fetch_pkg.sv
hdl/icache_array.sv
hdl/fetch_lookup.sv
hdl/line_refill.sv
hdl/fetch_unit.sv
testbench/fetch_checker.sv
testbench/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the fetch unit testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f fetch_unit.f \
  --top-module fetch_unit_tb \
  -o fetch_unit_sim

./obj_dir/fetch_unit_sim > sim.log
cat sim.log

if grep -q "Test failures found" sim.log; then
  exit 1
fi
exit 0

//--- testbench/fetch_vectors.txt
// columns: command, instructions to deliver, target pc, expected bus reads, cycle budget
// commands: 1 run, 2 random stall run, 3 redirect, 4 redirect during refill, 5 flush
// bus reads include the one instruction fetched ahead into the output register
00000001 0000001f 00000000 00000010 00000190
00000003 0000001e 30000000 00000000 00000060
00000002 00000014 00000000 0000000a 00000140
00000004 00000004 30000000 00000004 00000080
00000005 00000008 30000000 00000005 000000a0
00000003 00000008 0f000100 00000009 00000120
00000003 00000004 0f000100 00000005 000000a0
00000003 00000002 30000000 00000000 00000040
00000003 00000002 30001000 00000002 00000060
00000003 00000002 30000000 00000002 00000060
// end of the command list
00000000 00000000 00000000 00000000 00000000
